//--- common/rsa_cfg.svh
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// operand width
`define RSA_BITS    256
`define RSA_BYTES   (`RSA_BITS / 8)

// serial port word addresses
`define RX_BASE     5'd0
`define TX_BASE     5'd4
`define STATUS_BASE 5'd8

// status word flags
`define TX_OK_BIT   6
`define RX_OK_BIT   7

`endif

//--- common/rsa_pkg.sv
`default_nettype none

`include "rsa_cfg.svh"

package rsa_pkg;

    // operands, intermediates and results
    typedef logic [`RSA_BITS-1:0] rsa_word_t;

    // counts up to RSA_BITS+1
    typedef logic [$clog2(`RSA_BITS+2)-1:0] rsa_bitcnt_t;

    // square-and-multiply sequencer
    typedef enum logic [2:0] {
        IDLE,
        PREP,
        SQUARE,
        MULT,
        DONE
    } core_state_t;

endpackage

`default_nettype wire

//--- common/avm_pkg.sv
`default_nettype none

`include "rsa_cfg.svh"

package avm_pkg;

    typedef logic [4:0]  avm_addr_t;
    typedef logic [31:0] avm_data_t;

    // n and d are counted as one 64 byte run
    typedef logic [$clog2(2*`RSA_BYTES+1)-1:0] byte_cnt_t;

    typedef enum logic [2:0] {
        POLL_RX,
        READ_RX,
        POLL_TX,
        WRITE_TX,
        WAIT_CORE
    } wrap_state_t;

    typedef enum logic [1:0] {LOAD_N, LOAD_D, LOAD_DATA} wrap_phase_t;

endpackage

`default_nettype wire

//--- rsa_core/rsa_prep.sv
`default_nettype none
`timescale 1ns/1ps

`include "rsa_cfg.svh"

module rsa_prep (
    input  wire                    avm_clk,
    input  wire                    avm_rst,
    input  wire                    start,
    input  wire rsa_pkg::rsa_word_t value,
    input  wire rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t     scaled,
    output logic                   done
);
    import rsa_pkg::*;

    rsa_word_t          acc;
    logic [`RSA_BITS:0] dbl;
    logic [`RSA_BITS:0] red;
    rsa_bitcnt_t        cnt;
    logic               busy;
    logic               last;

    assign dbl = {acc, 1'b0};   // one spare bit for the carry
    assign red = (dbl >= {1'b0, modulus}) ? dbl - {1'b0, modulus} : dbl;
    assign last = busy && (cnt == rsa_bitcnt_t'(`RSA_BITS-1));
    assign scaled = acc;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= last;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // value assumed below n, so one subtraction per doubling is enough
    always_ff @(posedge avm_clk) begin
        if (start)
            acc <= value;
        else if (busy)
            acc <= red[`RSA_BITS-1:0];
    end

endmodule

`default_nettype wire

//--- rsa_core/rsa_mont.sv
`default_nettype none
`timescale 1ns/1ps

`include "rsa_cfg.svh"

module rsa_mont (
    input  wire                    avm_clk,
    input  wire                    avm_rst,
    input  wire                    start,
    input  wire rsa_pkg::rsa_word_t a,
    input  wire rsa_pkg::rsa_word_t b,
    input  wire rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t     product,
    output logic                   done
);
    import rsa_pkg::*;

    // sum stays below 2n between steps, up to 4n inside a step
    logic [`RSA_BITS+1:0] s_r;
    logic [`RSA_BITS+1:0] s_in;
    logic [`RSA_BITS+1:0] s_add;
    logic [`RSA_BITS+1:0] s_odd;
    logic [`RSA_BITS+1:0] s_nxt;
    logic [`RSA_BITS+1:0] s_sub;
    rsa_word_t            a_sh;
    logic                 a_bit;
    rsa_bitcnt_t          cnt;
    logic                 busy;
    logic                 last;

    // first step already runs in the start cycle
    assign s_in  = start ? '0 : s_r;
    assign a_bit = start ? a[0] : a_sh[0];
    assign s_add = s_in + (a_bit ? {2'b00, b} : '0);
    assign s_odd = s_add[0] ? s_add + {2'b00, modulus} : s_add;
    assign s_nxt = s_odd >> 1;
    assign s_sub = (s_r >= {2'b00, modulus}) ? s_r - {2'b00, modulus} : s_r;

    assign last    = busy && (cnt == rsa_bitcnt_t'(`RSA_BITS));
    assign product = s_r[`RSA_BITS-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= last;
            if (start) begin
                busy <= 1'b1;
                cnt  <= rsa_bitcnt_t'(1);
            end else if (last) begin
                busy <= 1'b0;   // subtraction cycle
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            s_r  <= s_nxt;
            a_sh <= a >> 1;
        end else if (last) begin
            s_r <= s_sub;
        end else if (busy) begin
            s_r  <= s_nxt;
            a_sh <= a_sh >> 1;
        end
    end

    a_mod_odd: assert property (@(posedge avm_clk) disable iff (avm_rst)
        busy |-> modulus[0]);

endmodule

`default_nettype wire

//--- rsa_core/rsa_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "rsa_cfg.svh"

module rsa_core (
    input  wire                    avm_clk,
    input  wire                    avm_rst,
    input  wire                    start,
    input  wire rsa_pkg::rsa_word_t msg,
    input  wire rsa_pkg::rsa_word_t exp,
    input  wire rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t     result,
    output logic                   finished
);
    import rsa_pkg::*;

    core_state_t state;
    rsa_word_t   acc;       // plain domain
    rsa_word_t   base;      // montgomery domain
    rsa_word_t   exp_sh;
    rsa_bitcnt_t bit_cnt;
    logic        prep_start;
    logic        prep_done;
    logic        mont_start;
    logic        mont_done;
    rsa_word_t   scaled;
    rsa_word_t   product;
    rsa_word_t   mont_a;
    logic        last_bit;

    assign prep_start = start && (state == IDLE);
    assign mont_a     = (state == MULT) ? acc : base;
    assign last_bit   = (bit_cnt == rsa_bitcnt_t'(`RSA_BITS-1));
    assign result     = acc;
    assign finished   = (state == DONE);

    rsa_prep u_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .value   (msg),
        .modulus (modulus),
        .scaled  (scaled),
        .done    (prep_done)
    );

    rsa_mont u_mont (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .a       (mont_a),
        .b       (base),        // base is b for both multiply and square
        .modulus (modulus),
        .product (product),
        .done    (mont_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= IDLE;
            mont_start <= 1'b0;
            bit_cnt    <= '0;
        end else begin
            mont_start <= 1'b0;
            case (state)
                IDLE: if (start) state <= PREP;
                PREP: if (prep_done) begin
                    bit_cnt    <= '0;
                    state      <= exp[0] ? MULT : SQUARE;
                    mont_start <= 1'b1;
                end
                MULT: if (mont_done) begin
                    state      <= SQUARE;
                    mont_start <= 1'b1;
                end
                SQUARE: if (mont_done) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        state <= DONE;
                    end else begin
                        state      <= exp_sh[1] ? MULT : SQUARE;   // peek next bit
                        mont_start <= 1'b1;
                    end
                end
                default: state <= IDLE;   // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            PREP: if (prep_done) begin
                base   <= scaled;
                acc    <= rsa_word_t'(1);
                exp_sh <= exp;
            end
            MULT: if (mont_done) acc <= product;
            SQUARE: if (mont_done) begin
                base   <= product;
                exp_sh <= exp_sh >> 1;
            end
            default: ;
        endcase
    end

    a_start_idle: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> state == IDLE);

endmodule

`default_nettype wire

//--- design/rsa_wrapper.sv
`default_nettype none
`timescale 1ns/1ps

`include "rsa_cfg.svh"

module rsa_wrapper (
    input  wire                    avm_clk,
    input  wire                    avm_rst,
    output avm_pkg::avm_addr_t     avm_address,
    output logic                   avm_read,
    output logic                   avm_write,
    input  wire avm_pkg::avm_data_t avm_readdata,
    output avm_pkg::avm_data_t     avm_writedata,
    input  wire                    avm_waitrequest
);
    import avm_pkg::*;
    import rsa_pkg::*;

    wrap_state_t state;
    wrap_phase_t phase;
    byte_cnt_t   byte_cnt;
    avm_addr_t   addr_r;
    logic        read_r;
    logic        write_r;
    logic        core_start;
    logic        core_finished;
    rsa_word_t   core_result;
    rsa_word_t   n_r;
    rsa_word_t   d_r;
    rsa_word_t   enc_r;
    rsa_word_t   dec_r;
    logic        xfer;
    logic        rx_take;
    logic        tx_sent;
    logic [7:0]  rx_byte;

    assign avm_address   = addr_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {24'd0, dec_r[`RSA_BITS-9 -: 8]};   // top byte is never sent

    assign xfer    = (read_r || write_r) && !avm_waitrequest;
    assign rx_take = (state == READ_RX) && xfer;
    assign tx_sent = (state == WRITE_TX) && xfer;
    assign rx_byte = avm_readdata[7:0];

    rsa_core u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .msg      (enc_r),
        .exp      (d_r),
        .modulus  (n_r),
        .result   (core_result),
        .finished (core_finished)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= POLL_RX;
            phase      <= LOAD_N;
            byte_cnt   <= '0;
            addr_r     <= `STATUS_BASE;
            read_r     <= 1'b1;
            write_r    <= 1'b0;
            core_start <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                POLL_RX: if (xfer && avm_readdata[`RX_OK_BIT]) begin
                    state  <= READ_RX;
                    addr_r <= `RX_BASE;
                end
                READ_RX: if (xfer) begin
                    state    <= POLL_RX;
                    addr_r   <= `STATUS_BASE;
                    byte_cnt <= byte_cnt + 1'b1;
                    case (phase)
                        LOAD_N: if (byte_cnt == byte_cnt_t'(`RSA_BYTES-1)) phase <= LOAD_D;
                        LOAD_D: if (byte_cnt == byte_cnt_t'(2*`RSA_BYTES-1)) begin
                            phase    <= LOAD_DATA;
                            byte_cnt <= '0;
                        end
                        default: if (byte_cnt == byte_cnt_t'(`RSA_BYTES-1)) begin
                            byte_cnt   <= '0;
                            read_r     <= 1'b0;
                            core_start <= 1'b1;
                            state      <= WAIT_CORE;
                        end
                    endcase
                end
                WAIT_CORE: if (core_finished) begin
                    state  <= POLL_TX;
                    read_r <= 1'b1;     // address still at status
                end
                POLL_TX: if (xfer && avm_readdata[`TX_OK_BIT]) begin
                    state   <= WRITE_TX;
                    read_r  <= 1'b0;
                    write_r <= 1'b1;
                    addr_r  <= `TX_BASE;
                end
                WRITE_TX: if (xfer) begin
                    write_r <= 1'b0;
                    read_r  <= 1'b1;
                    addr_r  <= `STATUS_BASE;
                    if (byte_cnt == byte_cnt_t'(`RSA_BYTES-2)) begin
                        byte_cnt <= '0;
                        state    <= POLL_RX;   // key kept, next block
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= POLL_TX;
                    end
                end
                default: state <= POLL_RX;
            endcase
        end
    end

    // msb first into the register of the current phase
    always_ff @(posedge avm_clk) begin
        if (rx_take) begin
            case (phase)
                LOAD_N:  n_r   <= {n_r[`RSA_BITS-9:0], rx_byte};
                LOAD_D:  d_r   <= {d_r[`RSA_BITS-9:0], rx_byte};
                default: enc_r <= {enc_r[`RSA_BITS-9:0], rx_byte};
            endcase
        end
        if (core_finished)
            dec_r <= core_result;
        else if (tx_sent)
            dec_r <= dec_r << 8;
    end

    a_no_rd_wr: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write));

    a_hold_on_wait: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write)
            && $stable(avm_writedata));

endmodule

`default_nettype wire

//--- sim/rsa_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "rsa_cfg.svh"

module rsa_tb;
    import rsa_pkg::*;
    import avm_pkg::*;

    localparam int BLOCKS      = 6;
    localparam int CORE_CYCLES = 2*`RSA_BITS*(`RSA_BITS+2) + `RSA_BITS + 1;
    localparam int BYTES       = 2*`RSA_BYTES + BLOCKS*(2*`RSA_BYTES - 1);
    localparam int MAX_CYCLES  = BLOCKS*CORE_CYCLES + 64*BYTES;

    logic        avm_clk;
    logic        avm_rst;
    avm_addr_t   avm_address;
    logic        avm_read;
    logic        avm_write;
    avm_data_t   avm_readdata;
    avm_data_t   avm_writedata;
    logic        avm_waitrequest;

    logic [15:0] lfsr;
    logic [7:0]  rx_q[$];
    logic [7:0]  tx_q[$];
    logic [7:0]  exp_q[$];
    int          exp_id[$];
    rsa_word_t   key_n;
    rsa_word_t   key_d;
    rsa_word_t   cipher;
    logic        rst_at_edge;
    logic        rx_ok_seen;    // status as last reported to the wrapper
    logic        tx_ok_seen;
    logic        pend_valid;
    logic        pend_read;
    avm_addr_t   pend_addr;
    avm_data_t   pend_wdata;
    avm_data_t   pend_rdata;
    logic [31:0] rnd;
    logic [7:0]  got;
    logic [7:0]  want;
    int          got_id;
    int          checked;
    int          cycles;

    rsa_wrapper uut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_readdata    (avm_readdata),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #4 avm_clk = ~avm_clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_word(output rsa_word_t w);
        logic [31:0] bits;
        for (int i = 0; i < `RSA_BITS / 16; i++) begin
            take_bits(16, bits);
            w = {w[`RSA_BITS-17:0], bits[15:0]};
        end
    endtask

    // plain square-and-multiply from the lsb up
    function automatic rsa_word_t ref_modexp(input rsa_word_t m, input rsa_word_t e,
                                             input rsa_word_t n);
        logic [2*`RSA_BITS-1:0] r;
        logic [2*`RSA_BITS-1:0] b;
        r = 1;
        b = m % n;
        for (int i = 0; i < `RSA_BITS; i++) begin
            if (e[i])
                r = (r * b) % n;
            b = (b * b) % n;
        end
        return r[`RSA_BITS-1:0];
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "single block";
            1:       return "key reuse";
            2:       return "edge ciphertext one";
            default: return "edge ciphertext n-1";
        endcase
    endfunction

    task automatic stop_run;
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic queue_block(input int id, input rsa_word_t c);
        rsa_word_t res;
        res = ref_modexp(c, key_d, key_n);
        for (int i = `RSA_BYTES-2; i >= 0; i--) begin
            exp_q.push_back(res[8*i +: 8]);
            exp_id.push_back(id);
        end
        for (int i = `RSA_BYTES-1; i >= 0; i--)
            rx_q.push_back(c[8*i +: 8]);
    endtask

    task automatic wait_checked(input int target);
        while (checked < target)
            @(posedge avm_clk);
    endtask

    // transfer that completed on the last edge
    task automatic finish_transfer;
        if (pend_read && pend_addr == `STATUS_BASE) begin
            rx_ok_seen = pend_rdata[`RX_OK_BIT];
            tx_ok_seen = pend_rdata[`TX_OK_BIT];
        end else if (pend_read && pend_addr == `RX_BASE) begin
            if (!rx_ok_seen) begin
                $display("wrapper read RX_BASE while RX_OK was last reported clear");
                stop_run();
            end
            if (rx_q.size() == 0) begin
                $display("wrapper read RX_BASE while the receive queue was empty");
                stop_run();
            end
            void'(rx_q.pop_front());
            rx_ok_seen = 1'b0;  // one byte per poll
        end else if (!pend_read && pend_addr == `TX_BASE) begin
            if (!tx_ok_seen) begin
                $display("wrapper wrote TX_BASE while TX_OK was last reported clear");
                stop_run();
            end
            check_value("tx upper bits", 32'd0, {8'd0, pend_wdata[31:8]});
            tx_q.push_back(pend_wdata[7:0]);
            tx_ok_seen = 1'b0;
        end else begin
            $display("wrapper accessed unmapped address %0d", pend_addr);
            stop_run();
        end
    endtask

    task automatic serve_request;
        logic rx_ok;
        logic tx_ok;
        pend_valid = avm_read || avm_write;
        pend_read  = avm_read;
        pend_addr  = avm_address;
        pend_wdata = avm_writedata;
        avm_readdata = '0;
        avm_waitrequest = 1'b0;
        if (pend_valid) begin
            take_bits(4, rnd);
            avm_waitrequest = (rnd[1:0] == 2'b11);  // about one stall in four
            rx_ok = rnd[2] && (rx_q.size() != 0);
            tx_ok = rnd[3];
            if (pend_read && pend_addr == `STATUS_BASE) begin
                avm_readdata[`RX_OK_BIT] = rx_ok;
                avm_readdata[`TX_OK_BIT] = tx_ok;
            end else if (pend_read && pend_addr == `RX_BASE && rx_q.size() != 0) begin
                avm_readdata[7:0] = rx_q[0];
            end
        end
        pend_rdata = avm_readdata;
    endtask

    // serial port slave
    always @(posedge avm_clk) begin
        rst_at_edge = avm_rst;
        #1;
        if (rst_at_edge) begin
            avm_waitrequest = 1'b1;
            avm_readdata = '0;
            pend_valid = 1'b0;
            rx_ok_seen = 1'b0;
            tx_ok_seen = 1'b0;
        end else begin
            if (pend_valid && !avm_waitrequest)
                finish_transfer();
            serve_request();
        end
    end

    // compare once the slave has queued this edge's write
    always @(posedge avm_clk) begin
        #2;
        while (tx_q.size() != 0) begin
            got = tx_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("wrapper wrote byte %0h when no output byte was expected", got);
                stop_run();
            end
            want = exp_q.pop_front();
            got_id = exp_id.pop_front();
            check_value(test_name(got_id), want, got);
            checked++;
        end
    end

    always @(posedge avm_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, only %0d output bytes were checked",
                     cycles, checked);
            stop_run();
        end
    end

    initial begin
        avm_clk = 1'b0;
        avm_rst = 1'b1;
        avm_readdata = '0;
        avm_waitrequest = 1'b1;
        lfsr = 16'd94;
        pend_valid = 1'b0;
        rx_ok_seen = 1'b0;
        tx_ok_seen = 1'b0;
        checked = 0;
        cycles = 0;

        random_word(key_n);
        key_n[`RSA_BITS-1] = 1'b1;
        key_n[0] = 1'b1;    // odd modulus
        random_word(key_d);
        key_d[0] = 1'b1;
        for (int i = `RSA_BYTES-1; i >= 0; i--)
            rx_q.push_back(key_n[8*i +: 8]);
        for (int i = `RSA_BYTES-1; i >= 0; i--)
            rx_q.push_back(key_d[8*i +: 8]);
        random_word(cipher);
        cipher[`RSA_BITS-1] = 1'b0; // keeps it below n
        queue_block(0, cipher);

        repeat (2) @(posedge avm_clk);
        #1;
        check_value("reset read", 32'd1, avm_read);
        check_value("reset write", 32'd0, avm_write);
        check_value("reset address", `STATUS_BASE, avm_address);
        repeat (2) @(posedge avm_clk);
        #1;
        avm_rst = 1'b0;
        @(posedge avm_clk);
        #1;
        check_value("post-reset read", 32'd1, avm_read);
        check_value("post-reset write", 32'd0, avm_write);
        check_value("post-reset address", `STATUS_BASE, avm_address);

        wait_checked(`RSA_BYTES-1);
        repeat (3) begin
            random_word(cipher);
            cipher[`RSA_BITS-1] = 1'b0;
            queue_block(1, cipher);
        end
        wait_checked(4*(`RSA_BYTES-1));
        queue_block(2, rsa_word_t'(1));
        queue_block(3, key_n - rsa_word_t'(1));
        wait_checked(BLOCKS*(`RSA_BYTES-1));

        // every input byte must be gone once the last block is out
        repeat (100) @(posedge avm_clk);
        check_value("unread input bytes", 32'd0, rx_q.size());
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rsa256.f
+incdir+common
common/rsa_pkg.sv
common/avm_pkg.sv
rsa_core/rsa_prep.sv
rsa_core/rsa_mont.sv
rsa_core/rsa_core.sv
design/rsa_wrapper.sv
sim/rsa_tb.sv
